// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f cache_top.f --top-module cache_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f cache_top.f \
		--top-module tb_cache_top -o tb_sim
	@out="$$(./obj_dir/tb_sim)"; echo "$$out"; \
		echo "$$out" | grep -q "^Simulation finished: PASS$$"

clean:
	rm -rf obj_dir

// File: cache_top.f
hw/cache_pkg.sv
hw/lookup_if.sv
hw/cache_control.sv
hw/tag_array.sv
hw/plru_array.sv
hw/data_array.sv
hw/cache_top.sv
verif/tb_mem_model.sv
verif/tb_cache_top.sv

// File: hw/cache_control.sv
// Cache controller FSM sequencing hits, dirty write-back, line refill and write-miss completion
`timescale 1ns/10ps

module cache_control (
    input  logic             clk,
    input  logic             rst,
    input  logic             cpu_valid,
    input  logic             cpu_write,
    input  cache_pkg::addr_t cpu_addr,
    input  logic             mem_resp,
    lookup_if.ctrl           lk,
    output logic             cpu_ready,
    output logic             mem_read,
    output logic             mem_write,
    output cache_pkg::addr_t mem_addr
);
    import cache_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t next_state;
    way_t        way_q;
    index_t      set_index;
    addr_t       refill_addr;
    addr_t       evict_addr;

    assign set_index   = cpu_addr[OFFSET_BITS +: INDEX_BITS];
    assign refill_addr = {cpu_addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign evict_addr  = {lk.victim_tag, set_index, {OFFSET_BITS{1'b0}}};

    always_comb
    begin
        next_state = state_q;
        cpu_ready  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_addr   = refill_addr;
        lk.way     = way_q;
        lk.fill    = 1'b0;
        lk.store   = 1'b0;
        lk.touch   = 1'b0;

        case (state_q)
            idle:
            begin
                // Victim way equals the hit way on a hit
                lk.way = lk.victim_way;
                if (cpu_valid)
                begin
                    if (lk.hit)
                    begin
                        cpu_ready = 1'b1;
                        lk.store  = cpu_write;
                        lk.touch  = 1'b1;
                    end
                    else if (lk.victim_dirty)
                        next_state = write_back;
                    else
                        next_state = refill;
                end
            end

            write_back:
            begin
                mem_write = 1'b1;
                mem_addr  = evict_addr;
                if (mem_resp)
                    next_state = refill;
            end

            refill:
            begin
                mem_read = 1'b1;
                if (mem_resp)
                begin
                    lk.fill  = 1'b1;
                    lk.touch = 1'b1;
                    if (cpu_write)
                        next_state = write_hit;
                    else
                        next_state = respond;
                end
            end

            write_hit:
            begin
                lk.store   = 1'b1;
                next_state = respond;
            end

            respond:
            begin
                cpu_ready  = 1'b1;
                next_state = idle;
            end

            default:
                next_state = idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= idle;
            way_q   <= '0;
        end
        else
        begin
            state_q <= next_state;
            // Working way is fixed for the whole miss sequence
            if (state_q == idle && cpu_valid && !lk.hit)
                way_q <= lk.victim_way;
        end
    end

endmodule

// File: hw/cache_pkg.sv
// Geometry, address-field types and controller states shared by all cache RTL blocks

package cache_pkg;

    localparam int OFFSET_BITS   = 5;
    localparam int WORD_SEL_BITS = 3;
    localparam int INDEX_BITS    = 5;
    localparam int NUM_SETS      = 32;
    localparam int NUM_WAYS      = 4;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // Eight words per line
    typedef logic [(8 << OFFSET_BITS) - 1:0] line_t;

    // Address bits above index and offset
    typedef logic [31 - INDEX_BITS - OFFSET_BITS:0] tag_t;

    typedef logic [INDEX_BITS-1:0]       index_t;
    typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

    // One tree node per pair plus the root
    typedef logic [2:0] plru_t;

    typedef enum logic [2:0] {
        idle,
        write_back,
        refill,
        write_hit,
        respond
    } ctrl_state_t;

endpackage

// File: hw/cache_top.sv
// Four-way write-back cache top level joining the processor port to the line memory port
`timescale 1ns/10ps

module cache_top (
    input  logic             clk,
    input  logic             rst,

    input  logic             cpu_valid,
    input  logic             cpu_write,
    input  cache_pkg::addr_t cpu_addr,
    input  cache_pkg::word_t cpu_wdata,
    output logic             cpu_ready,
    output cache_pkg::word_t cpu_rdata,

    output logic             mem_read,
    output logic             mem_write,
    output cache_pkg::addr_t mem_addr,
    output cache_pkg::line_t mem_wdata,
    input  logic             mem_resp,
    input  cache_pkg::line_t mem_rdata
);
    import cache_pkg::*;

    tag_t                     addr_tag;
    index_t                   addr_index;
    logic [WORD_SEL_BITS-1:0] addr_word;
    way_t                     plru_way;

    // Address fields
    assign addr_tag   = cpu_addr[31 -: $bits(tag_t)];
    assign addr_index = cpu_addr[OFFSET_BITS +: INDEX_BITS];
    assign addr_word  = cpu_addr[OFFSET_BITS-1 -: WORD_SEL_BITS];

    lookup_if lk_i ();

    cache_control ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .cpu_valid (cpu_valid),
        .cpu_write (cpu_write),
        .cpu_addr  (cpu_addr),
        .mem_resp  (mem_resp),
        .lk        (lk_i.ctrl),
        .cpu_ready (cpu_ready),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_addr  (mem_addr)
    );

    tag_array tag_i (
        .clk      (clk),
        .rst      (rst),
        .index    (addr_index),
        .tag      (addr_tag),
        .plru_way (plru_way),
        .lk       (lk_i.array)
    );

    plru_array plru_i (
        .clk      (clk),
        .rst      (rst),
        .index    (addr_index),
        .lk       (lk_i.array),
        .plru_way (plru_way)
    );

    data_array data_i (
        .clk       (clk),
        .index     (addr_index),
        .word_sel  (addr_word),
        .wdata     (cpu_wdata),
        .fill_line (mem_rdata),
        .lk        (lk_i.array)
    );

    assign mem_wdata = lk_i.victim_line;
    assign cpu_rdata = lk_i.rd_word;

endmodule

// File: hw/data_array.sv
// Cache line storage per set and way with word access and whole-line refill
`timescale 1ns/10ps

module data_array (
    input  logic                                clk,
    input  cache_pkg::index_t                   index,
    input  logic [cache_pkg::WORD_SEL_BITS-1:0] word_sel,
    input  cache_pkg::word_t                    wdata,
    input  cache_pkg::line_t                    fill_line,
    lookup_if.array                             lk
);
    import cache_pkg::*;

    line_t line_mem [NUM_SETS][NUM_WAYS];
    line_t cur_line;

    always_ff @(posedge clk)
    begin
        if (lk.fill)
            line_mem[index][lk.way] <= fill_line;
        else if (lk.store)
            line_mem[index][lk.way][word_sel * $bits(word_t) +: $bits(word_t)] <= wdata;
    end

    assign cur_line = line_mem[index][lk.way];

    // Same line serves read data and write-back payload
    assign lk.rd_word     = cur_line[word_sel * $bits(word_t) +: $bits(word_t)];
    assign lk.victim_line = cur_line;

endmodule

// File: hw/lookup_if.sv
// Per-access commands and lookup results shared by the cache controller and its arrays
`timescale 1ns/10ps

interface lookup_if;
    import cache_pkg::*;

    // Commands from the controller
    way_t  way;
    logic  fill;
    logic  store;
    logic  touch;

    // Lookup results from the arrays
    logic  hit;
    way_t  hit_way;
    way_t  victim_way;
    logic  victim_dirty;
    tag_t  victim_tag;
    word_t rd_word;
    line_t victim_line;

    modport ctrl (
        output way, fill, store, touch,
        input  hit, victim_way, victim_dirty, victim_tag
    );

    modport array (
        input  way, fill, store, touch,
        output hit, hit_way, victim_way, victim_dirty, victim_tag,
        output rd_word, victim_line
    );

endinterface

// File: hw/plru_array.sv
// Tree pseudo-LRU bits per set, updated on access, giving the replacement way of the set
`timescale 1ns/10ps

module plru_array (
    input  logic              clk,
    input  logic              rst,
    input  cache_pkg::index_t index,
    lookup_if.array           lk,
    output cache_pkg::way_t   plru_way
);
    import cache_pkg::*;

    plru_t tree_q [NUM_SETS];
    plru_t tree_cur;

    assign tree_cur = tree_q[index];

    // Root picks the pair, then the pair's own bit picks the way
    assign plru_way = tree_cur[0] ? {1'b1, tree_cur[2]} : {1'b0, tree_cur[1]};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < NUM_SETS; s++)
                tree_q[s] <= '0;
        end
        else if (lk.touch)
        begin
            // Point away from the way just used
            tree_q[index][0] <= ~lk.way[1];
            if (lk.way[1])
                tree_q[index][2] <= ~lk.way[0];
            else
                tree_q[index][1] <= ~lk.way[0];
        end
    end

endmodule

// File: hw/tag_array.sv
// Valid, dirty and tag storage per set and way with hit detection and victim choice
`timescale 1ns/10ps

module tag_array (
    input  logic              clk,
    input  logic              rst,
    input  cache_pkg::index_t index,
    input  cache_pkg::tag_t   tag,
    input  cache_pkg::way_t   plru_way,
    lookup_if.array           lk
);
    import cache_pkg::*;

    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    logic [NUM_WAYS-1:0] dirty_q [NUM_SETS];
    tag_t                tag_mem [NUM_SETS][NUM_WAYS];

    logic free_found;
    way_t free_way;
    way_t chosen_way;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < NUM_SETS; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end
        else if (lk.fill)
        begin
            valid_q[index][lk.way] <= 1'b1;
            dirty_q[index][lk.way] <= 1'b0;
        end
        else if (lk.store)
            dirty_q[index][lk.way] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (lk.fill)
            tag_mem[index][lk.way] <= tag;
    end

    // Descending scan so the lowest invalid way wins
    always_comb
    begin
        lk.hit     = 1'b0;
        lk.hit_way = '0;
        free_found = 1'b0;
        free_way   = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--)
        begin
            if (valid_q[index][w] && tag_mem[index][w] == tag)
            begin
                lk.hit     = 1'b1;
                lk.hit_way = way_t'(w);
            end
            if (!valid_q[index][w])
            begin
                free_found = 1'b1;
                free_way   = way_t'(w);
            end
        end
    end

    assign chosen_way      = lk.hit ? lk.hit_way : (free_found ? free_way : plru_way);
    assign lk.victim_way   = chosen_way;
    assign lk.victim_dirty = dirty_q[index][chosen_way];
    assign lk.victim_tag   = tag_mem[index][chosen_way];

endmodule

// File: verif/tb_cache_top.sv
// Testbench for the four-way cache, driving processor requests and checking data and memory protocol
`timescale 1ns/10ps

module tb_cache_top;
    import cache_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    logic  clk;
    logic  rst;
    logic  cpu_valid;
    logic  cpu_write;
    addr_t cpu_addr;
    word_t cpu_wdata;
    logic  cpu_ready;
    word_t cpu_rdata;
    logic  mem_read;
    logic  mem_write;
    addr_t mem_addr;
    line_t mem_wdata;
    logic  mem_resp;
    line_t mem_rdata;

    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     read_cycles = 0;
    logic   request_seen = 1'b0;
    logic   held_valid;
    logic   held_read;
    logic   held_write;
    addr_t  held_addr;
    line_t  held_wdata;

    // Written words by word address
    word_t  shadow [addr_t];
    // Completed memory transfers in order
    logic   xfer_write [$];
    addr_t  xfer_addr [$];

    cache_top dut_i (.*);
    tb_mem_model mem_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_error(input string msg);
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got == exp)
        else
        begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic addr_t compose_addr(input tag_t tag, input index_t index,
                                           input logic [2:0] word);
        return {tag, index, word, 2'b00};
    endfunction

    function automatic word_t expected_word(input addr_t addr);
        if (shadow.exists(addr >> 2))
            return shadow[addr >> 2];
        return word_t'(addr >> 2);
    endfunction

    // Memory protocol watch
    always @(posedge clk)
    begin
        if (rst)
            held_valid = 1'b0;
        else
        begin
            assert (!(mem_read && mem_write))
            else
                report_error("mem_read and mem_write high together");
            assert (request_seen || (!cpu_ready && !mem_read && !mem_write))
            else
                report_error("cache active before the first request");
            assert (!(mem_read || mem_write) || !cpu_ready)
            else
                report_error("cpu_ready high during a memory transfer");
            if (held_valid)
            begin
                assert (mem_read == held_read && mem_write == held_write)
                else
                    report_error("memory request changed before mem_resp");
                check_value("mem_addr", mem_addr, held_addr);
                assert (!held_write || mem_wdata == held_wdata)
                else
                    report_error("mem_wdata changed before mem_resp");
            end
            if (mem_resp && (mem_read || mem_write))
            begin
                xfer_write.push_back(mem_write);
                xfer_addr.push_back(mem_addr);
            end
            if (mem_read)
                read_cycles++;
            held_valid = (mem_read || mem_write) && !mem_resp;
            held_read  = mem_read;
            held_write = mem_write;
            held_addr  = mem_addr;
            held_wdata = mem_wdata;
        end
    end

    task automatic finish_run();
        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic cpu_access(input logic write, input addr_t addr, input word_t wdata,
                              output word_t rdata, output int latency);
        logic done;
        @(negedge clk);
        request_seen = 1'b1;
        cpu_valid    = 1'b1;
        cpu_write    = write;
        cpu_addr     = addr;
        cpu_wdata    = wdata;
        latency      = 0;
        rdata        = '0;
        done         = 1'b0;
        while (!done)
        begin
            @(posedge clk);
            if (cpu_ready)
            begin
                rdata = cpu_rdata;
                done  = 1'b1;
            end
            else if (latency == TIMEOUT_CYCLES)
            begin
                report_error($sformatf("timeout, no cpu_ready within %0d cycles for address %h",
                                       TIMEOUT_CYCLES, addr));
                finish_run();
            end
            else
                latency++;
        end
        @(negedge clk);
        cpu_valid = 1'b0;
    endtask

    task automatic read_and_check(input addr_t addr);
        word_t got;
        int    latency;
        cpu_access(1'b0, addr, '0, got, latency);
        check_value("cpu_rdata", got, expected_word(addr));
    endtask

    task automatic write_word(input addr_t addr, input word_t data);
        word_t got;
        int    latency;
        cpu_access(1'b1, addr, data, got, latency);
        shadow[addr >> 2] = data;
    endtask

    task automatic check_transfer(input int pos, input logic is_write, input addr_t addr);
        assert (pos < xfer_addr.size())
        else
            report_error($sformatf("memory transfer %0d never happened", pos));
        if (pos < xfer_addr.size())
        begin
            check_value("mem_write", 32'(xfer_write[pos]), 32'(is_write));
            check_value("mem_addr", xfer_addr[pos], addr);
        end
    endtask

    task automatic read_miss_then_hit();
        addr_t addr;
        word_t got;
        int    latency;
        int    reads_before;
        addr = compose_addr(22'h0123, 5'd4, 3'd5);
        cpu_access(1'b0, addr, '0, got, latency);
        check_value("cpu_rdata", got, word_t'(addr >> 2));
        assert (latency > 0)
        else
            report_error("first read of a line completed without a miss");
        reads_before = read_cycles;
        cpu_access(1'b0, addr, '0, got, latency);
        check_value("cpu_rdata", got, word_t'(addr >> 2));
        check_value("cpu_ready latency", 32'(latency), 32'd0);
        check_value("mem_read cycles", 32'(read_cycles - reads_before), 32'd0);
    endtask

    // Ten tags over three sets force dirty and clean evictions
    task automatic random_traffic();
        addr_t addr;
        word_t data;
        for (int n = 0; n < 300; n++)
        begin
            addr = compose_addr(tag_t'(32'h3a0 + $unsigned($random(seed)) % 10),
                                index_t'($unsigned($random(seed)) % 3),
                                3'($random(seed)));
            data = $random(seed);
            if ($random(seed) % 2 == 0)
                write_word(addr, data);
            else
                read_and_check(addr);
        end
    endtask

    task automatic set_eviction();
        tag_t  tags [6];
        addr_t dirty_addr;
        for (int k = 0; k < 6; k++)
            tags[k] = tag_t'(32'h1000 + k * 3);
        // Dirty line lands in way 0, clean lines in ways 1 to 3
        dirty_addr = compose_addr(tags[0], 5'd9, 3'd3);
        write_word(dirty_addr, 32'hc0de_5a5a);
        for (int k = 1; k < 4; k++)
            read_and_check(compose_addr(tags[k], 5'd9, 3'd0));
        // Tree points at way 0 after touching ways 0 to 3
        xfer_write.delete();
        xfer_addr.delete();
        read_and_check(compose_addr(tags[4], 5'd9, 3'd0));
        check_value("memory transfer count", 32'(xfer_addr.size()), 32'd2);
        check_transfer(0, 1'b1, compose_addr(tags[0], 5'd9, 3'd0));
        check_transfer(1, 1'b0, compose_addr(tags[4], 5'd9, 3'd0));
        // Next victim is way 2, which is clean
        xfer_write.delete();
        xfer_addr.delete();
        read_and_check(compose_addr(tags[5], 5'd9, 3'd0));
        check_value("memory transfer count", 32'(xfer_addr.size()), 32'd1);
        check_transfer(0, 1'b0, compose_addr(tags[5], 5'd9, 3'd0));
        read_and_check(dirty_addr);
    endtask

    initial
    begin
        seed      = 29;
        rst       = 1'b1;
        cpu_valid = 1'b0;
        cpu_write = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // Quiet cycles before the first request
        repeat (4) @(negedge clk);
        read_miss_then_hit();
        random_traffic();
        set_eviction();
        finish_run();
    end

endmodule

// File: verif/tb_mem_model.sv
// Behavioral line memory for the cache testbench, answering each request after a random delay
`timescale 1ns/10ps

module tb_mem_model (
    input  logic             clk,
    input  logic             rst,
    input  logic             mem_read,
    input  logic             mem_write,
    input  cache_pkg::addr_t mem_addr,
    input  cache_pkg::line_t mem_wdata,
    output logic             mem_resp,
    output cache_pkg::line_t mem_rdata
);
    import cache_pkg::*;

    line_t  lines [addr_t];
    integer seed;
    int     wait_left;
    logic   busy;

    // Every word starts out holding its own word address
    function automatic line_t initial_line(input addr_t line_addr);
        line_t result;
        for (int i = 0; i < 8; i++)
            result[i*32 +: 32] = word_t'(line_addr >> 2) + word_t'(i);
        return result;
    endfunction

    initial
    begin
        seed      = 29;
        mem_resp  = 1'b0;
        mem_rdata = '0;
        wait_left = 0;
        busy      = 1'b0;
    end

    // Response is held for exactly one cycle
    always @(negedge clk)
    begin
        if (rst || mem_resp)
        begin
            mem_resp = 1'b0;
            busy     = 1'b0;
        end
        else if (mem_read || mem_write)
        begin
            if (!busy)
            begin
                busy      = 1'b1;
                wait_left = 1 + int'($unsigned($random(seed)) % 8);
            end
            wait_left = wait_left - 1;
            if (wait_left == 0)
            begin
                if (mem_write)
                    lines[mem_addr] = mem_wdata;
                else if (lines.exists(mem_addr))
                    mem_rdata = lines[mem_addr];
                else
                    mem_rdata = initial_line(mem_addr);
                mem_resp = 1'b1;
            end
        end
    end

endmodule
